//--- hw/xif_core_pkg.sv
/*
 * Core-side widths of the narrow extension interface
 */
package xif_core_pkg;

  // Instruction id carried on issue, commit and result
  localparam int unsigned CORE_ID_WIDTH = 4;
  localparam int unsigned NUM_IDS = 2 ** CORE_ID_WIDTH;

  // Source operands read by the core per issue
  localparam int unsigned CORE_NUM_RS = 2;

  // Data path and instruction word
  localparam int unsigned XLEN = 32;
  localparam int unsigned INSTR_WIDTH = 32;

  // Destination register index
  localparam int unsigned RF_ADDR_WIDTH = 5;

endpackage

//--- hw/xif_copro_pkg.sv
/*
 * Coprocessor-side widths, custom opcodes and function codes,
 * instruction word views and configuration register map
 */
package xif_copro_pkg;

  localparam int unsigned COPRO_ID_WIDTH = 4;

  // Third slot exists on the wide side but is never filled
  localparam int unsigned COPRO_NUM_RS = 3;

  // Major opcodes of the R-type and I-type groups
  localparam logic [6:0] OPC_CUSTOM0 = 7'b000_1011;
  localparam logic [6:0] OPC_CUSTOM1 = 7'b010_1011;

  // R-type group needs funct7 zero
  localparam logic [2:0] F3_MIN = 3'd0;
  localparam logic [2:0] F3_MAX = 3'd1;
  localparam logic [2:0] F3_ABSDIFF = 3'd2;

  // I-type group
  localparam logic [2:0] F3_ADDI = 3'd0;
  localparam logic [2:0] F3_RORI = 3'd1;

  // Configuration register addresses
  localparam logic CFG_ADDR_CTRL = 1'b0;
  localparam logic CFG_ADDR_COUNT = 1'b1;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr_i_t;

  // Same word, field layout picked by the opcode
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } copro_instr_u;

endpackage

//--- hw/xif_adapter.sv
/*
 * Narrow-to-wide extension interface adapter with a per-id
 * commit scoreboard and a one-entry result buffer toward the core
 */
module xif_adapter (
  input  logic clk_i,
  input  logic rst_n_i,

  // Core-side issue
  input  logic                                      x_issue_valid_i,
  output logic                                      x_issue_ready_o,
  input  logic [xif_core_pkg::CORE_ID_WIDTH-1:0]    x_issue_id_i,
  input  logic [xif_core_pkg::INSTR_WIDTH-1:0]      x_issue_instr_i,
  input  logic [xif_core_pkg::XLEN-1:0]             x_issue_rs0_i,
  input  logic [xif_core_pkg::XLEN-1:0]             x_issue_rs1_i,
  input  logic [xif_core_pkg::CORE_NUM_RS-1:0]      x_issue_rs_valid_i,
  output logic                                      x_issue_accept_o,
  output logic                                      x_issue_writeback_o,
  output logic [xif_core_pkg::CORE_NUM_RS-1:0]      x_issue_register_read_o,

  // Core-side commit
  input  logic                                      x_commit_valid_i,
  input  logic [xif_core_pkg::CORE_ID_WIDTH-1:0]    x_commit_id_i,
  input  logic                                      x_commit_kill_i,

  // Core-side result
  output logic                                      x_result_valid_o,
  input  logic                                      x_result_ready_i,
  output logic [xif_core_pkg::CORE_ID_WIDTH-1:0]    x_result_id_o,
  output logic [xif_core_pkg::XLEN-1:0]             x_result_data_o,
  output logic [xif_core_pkg::RF_ADDR_WIDTH-1:0]    x_result_rd_o,
  output logic                                      x_result_we_o,

  // Coprocessor-side issue
  output logic                                      copro_issue_valid_o,
  input  logic                                      copro_issue_ready_i,
  output logic [xif_copro_pkg::COPRO_ID_WIDTH-1:0]  copro_issue_id_o,
  output xif_copro_pkg::copro_instr_u               copro_issue_instr_o,
  output logic [xif_core_pkg::XLEN-1:0]             copro_issue_rs0_o,
  output logic [xif_core_pkg::XLEN-1:0]             copro_issue_rs1_o,
  output logic [xif_core_pkg::XLEN-1:0]             copro_issue_rs2_o,
  output logic [xif_copro_pkg::COPRO_NUM_RS-1:0]    copro_issue_rs_valid_o,
  input  logic                                      copro_issue_accept_i,
  input  logic                                      copro_issue_writeback_i,

  // Coprocessor-side result
  input  logic                                      copro_result_valid_i,
  output logic                                      copro_result_ready_o,
  input  logic [xif_copro_pkg::COPRO_ID_WIDTH-1:0]  copro_result_id_i,
  input  logic [xif_core_pkg::XLEN-1:0]             copro_result_data_i,
  input  logic [xif_core_pkg::RF_ADDR_WIDTH-1:0]    copro_result_rd_i,
  input  logic                                      copro_result_we_i
);

  import xif_core_pkg::*;
  import xif_copro_pkg::*;

  logic [NUM_IDS-1:0]       committed_q;
  logic [NUM_IDS-1:0]       killed_q;
  logic                     res_valid_q;
  logic [CORE_ID_WIDTH-1:0] res_id_q;
  logic [XLEN-1:0]          res_data_q;
  logic [RF_ADDR_WIDTH-1:0] res_rd_q;
  logic                     res_we_q;
  logic                     issue_block;
  logic                     out_free;
  logic                     res_committed;
  logic                     res_killed;
  logic                     res_load;

  // Hold new issues while the core leaves a result sitting in the buffer
  assign issue_block = res_valid_q & ~x_result_ready_i;

  assign copro_issue_valid_o    = x_issue_valid_i & ~issue_block;
  assign x_issue_ready_o        = copro_issue_ready_i & ~issue_block;
  assign copro_issue_id_o       = x_issue_id_i;
  assign copro_issue_instr_o    = x_issue_instr_i;
  assign copro_issue_rs0_o      = x_issue_rs0_i;
  assign copro_issue_rs1_o      = x_issue_rs1_i;
  assign copro_issue_rs2_o      = '0;
  assign copro_issue_rs_valid_o = {{(COPRO_NUM_RS - CORE_NUM_RS){1'b0}}, x_issue_rs_valid_i};

  assign x_issue_accept_o        = copro_issue_accept_i;
  assign x_issue_writeback_o     = copro_issue_writeback_i;
  // Core always reads both sources
  assign x_issue_register_read_o = '1;

  // A result waits at the ALU until its id has been committed
  assign res_committed        = committed_q[copro_result_id_i];
  assign res_killed           = killed_q[copro_result_id_i];
  assign out_free             = ~res_valid_q | x_result_ready_i;
  assign copro_result_ready_o = res_committed & (res_killed | out_free);
  assign res_load             = copro_result_valid_i & copro_result_ready_o & ~res_killed;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      committed_q <= '0;
      killed_q    <= '0;
    end else begin
      if (copro_result_valid_i && copro_result_ready_o) begin
        committed_q[copro_result_id_i] <= 1'b0;
        killed_q[copro_result_id_i]    <= 1'b0;
      end
      // Later write wins if a reused id commits in the same cycle
      if (x_commit_valid_i) begin
        committed_q[x_commit_id_i] <= 1'b1;
        killed_q[x_commit_id_i]    <= x_commit_kill_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (res_load) begin
      res_valid_q <= 1'b1;
    end else if (x_result_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_load) begin
      res_id_q   <= copro_result_id_i;
      res_data_q <= copro_result_data_i;
      res_rd_q   <= copro_result_rd_i;
      res_we_q   <= copro_result_we_i;
    end
  end

  assign x_result_valid_o = res_valid_q;
  assign x_result_id_o    = res_id_q;
  assign x_result_data_o  = res_data_q;
  assign x_result_rd_o    = res_rd_q;
  assign x_result_we_o    = res_we_q;

endmodule

//--- hw/xif_copro_alu.sv
/*
 * Two-stage coprocessor for the custom min/max/absdiff/addi/rori ops
 */
module xif_copro_alu (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic enable_i,

  input  logic                                      valid_i,
  output logic                                      ready_o,
  input  logic [xif_copro_pkg::COPRO_ID_WIDTH-1:0]  id_i,
  input  xif_copro_pkg::copro_instr_u               instr_i,
  input  logic [xif_core_pkg::XLEN-1:0]             rs0_i,
  input  logic [xif_core_pkg::XLEN-1:0]             rs1_i,
  input  logic [xif_core_pkg::XLEN-1:0]             rs2_i,
  input  logic [xif_copro_pkg::COPRO_NUM_RS-1:0]    rs_valid_i,
  output logic                                      accept_o,
  output logic                                      writeback_o,

  output logic                                      valid_o,
  input  logic                                      ready_i,
  output logic [xif_copro_pkg::COPRO_ID_WIDTH-1:0]  id_o,
  output logic [xif_core_pkg::XLEN-1:0]             data_o,
  output logic [xif_core_pkg::RF_ADDR_WIDTH-1:0]    rd_o,
  output logic                                      we_o,

  output logic                                      accept_pulse_o
);

  import xif_core_pkg::*;
  import xif_copro_pkg::*;

  logic                      is_rtype;
  logic                      is_itype;
  logic                      legal;
  logic                      take;
  logic                      s1_valid_q;
  logic                      s1_itype_q;
  logic [2:0]                s1_funct3_q;
  logic [XLEN-1:0]           s1_a_q;
  logic [XLEN-1:0]           s1_b_q;
  logic [COPRO_ID_WIDTH-1:0] s1_id_q;
  logic [RF_ADDR_WIDTH-1:0]  s1_rd_q;
  logic                      s1_adv;
  logic                      s2_valid_q;
  logic                      s2_free;
  logic [XLEN-1:0]           s2_data_q;
  logic [COPRO_ID_WIDTH-1:0] s2_id_q;
  logic [RF_ADDR_WIDTH-1:0]  s2_rd_q;
  logic [XLEN-1:0]           result;
  logic [2*XLEN-1:0]         rot;

  assign is_rtype = (instr_i.r.opcode == OPC_CUSTOM0);
  assign is_itype = (instr_i.i.opcode == OPC_CUSTOM1);

  always_comb begin
    legal = 1'b0;
    if (is_rtype) begin
      legal = (instr_i.r.funct7 == 7'd0) && (rs_valid_i[1:0] == 2'b11) &&
              (instr_i.r.funct3 inside {F3_MIN, F3_MAX, F3_ABSDIFF});
    end else if (is_itype) begin
      legal = rs_valid_i[0] && (instr_i.i.funct3 inside {F3_ADDI, F3_RORI});
    end
  end

  assign accept_o       = enable_i & legal;
  assign writeback_o    = accept_o;
  assign take           = valid_i & ready_o & accept_o;
  assign accept_pulse_o = take;

  // Stage 2 empties or hands off; stage 1 moves only then
  assign s2_free = ~s2_valid_q | ready_i;
  assign s1_adv  = s1_valid_q & s2_free;
  assign ready_o = ~s1_valid_q | s2_free;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (take) begin
        s1_valid_q <= 1'b1;
      end else if (s1_adv) begin
        s1_valid_q <= 1'b0;
      end
      if (s1_adv) begin
        s2_valid_q <= 1'b1;
      end else if (ready_i) begin
        s2_valid_q <= 1'b0;
      end
    end
  end

  // I-type carries the sign-extended immediate as its second operand
  always_ff @(posedge clk_i) begin
    if (take) begin
      s1_itype_q  <= is_itype;
      s1_funct3_q <= instr_i.r.funct3;
      s1_a_q      <= rs0_i;
      s1_b_q      <= is_itype ? {{(XLEN - 12){instr_i.i.imm12[11]}}, instr_i.i.imm12} : rs1_i;
      s1_id_q     <= id_i;
      s1_rd_q     <= instr_i.r.rd;
    end
  end

  assign rot = {s1_a_q, s1_a_q} >> s1_b_q[4:0];

  always_comb begin
    result = s1_a_q + s1_b_q;
    if (s1_itype_q) begin
      if (s1_funct3_q == F3_RORI) begin
        result = rot[XLEN-1:0];
      end
    end else begin
      case (s1_funct3_q)
        F3_MIN:  result = ($signed(s1_a_q) < $signed(s1_b_q)) ? s1_a_q : s1_b_q;
        F3_MAX:  result = ($signed(s1_a_q) > $signed(s1_b_q)) ? s1_a_q : s1_b_q;
        default: result = ($signed(s1_a_q) > $signed(s1_b_q)) ? s1_a_q - s1_b_q
                                                               : s1_b_q - s1_a_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_adv) begin
      s2_data_q <= result;
      s2_id_q   <= s1_id_q;
      s2_rd_q   <= s1_rd_q;
    end
  end

  assign valid_o = s2_valid_q;
  assign id_o    = s2_id_q;
  assign data_o  = s2_data_q;
  assign rd_o    = s2_rd_q;
  assign we_o    = 1'b1;

endmodule

//--- hw/xif_cfg_regs.sv
/*
 * Coprocessor enable register and accepted-instruction counter
 */
module xif_cfg_regs (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cfg_we_i,
  input  logic                          cfg_addr_i,
  input  logic [xif_core_pkg::XLEN-1:0] cfg_wdata_i,
  output logic [xif_core_pkg::XLEN-1:0] cfg_rdata_o,
  input  logic                          accept_pulse_i,
  output logic                          enable_o
);

  import xif_core_pkg::*;
  import xif_copro_pkg::*;

  logic            enable_q;
  logic [XLEN-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
    end else if (cfg_we_i && cfg_addr_i == CFG_ADDR_CTRL) begin
      enable_q <= cfg_wdata_i[0];
    end
  end

  // Any write to COUNT clears it and beats a same-cycle accept
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (cfg_we_i && cfg_addr_i == CFG_ADDR_COUNT) begin
      count_q <= '0;
    end else if (accept_pulse_i) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign cfg_rdata_o = (cfg_addr_i == CFG_ADDR_CTRL) ? {{(XLEN - 1){1'b0}}, enable_q}
                                                     : count_q;
  assign enable_o    = enable_q;

endmodule

//--- hw/xif_subsys_top.sv
/*
 * Extension subsystem top with the adapter, coprocessor ALU and config registers
 */
module xif_subsys_top (
  input  logic clk_i,
  input  logic rst_n_i,

  input  logic                                   x_issue_valid_i,
  output logic                                   x_issue_ready_o,
  input  logic [xif_core_pkg::CORE_ID_WIDTH-1:0] x_issue_id_i,
  input  logic [xif_core_pkg::INSTR_WIDTH-1:0]   x_issue_instr_i,
  input  logic [xif_core_pkg::XLEN-1:0]          x_issue_rs0_i,
  input  logic [xif_core_pkg::XLEN-1:0]          x_issue_rs1_i,
  input  logic [xif_core_pkg::CORE_NUM_RS-1:0]   x_issue_rs_valid_i,
  output logic                                   x_issue_accept_o,
  output logic                                   x_issue_writeback_o,
  output logic [xif_core_pkg::CORE_NUM_RS-1:0]   x_issue_register_read_o,

  input  logic                                   x_commit_valid_i,
  input  logic [xif_core_pkg::CORE_ID_WIDTH-1:0] x_commit_id_i,
  input  logic                                   x_commit_kill_i,

  output logic                                   x_result_valid_o,
  input  logic                                   x_result_ready_i,
  output logic [xif_core_pkg::CORE_ID_WIDTH-1:0] x_result_id_o,
  output logic [xif_core_pkg::XLEN-1:0]          x_result_data_o,
  output logic [xif_core_pkg::RF_ADDR_WIDTH-1:0] x_result_rd_o,
  output logic                                   x_result_we_o,

  input  logic                                   cfg_we_i,
  input  logic                                   cfg_addr_i,
  input  logic [xif_core_pkg::XLEN-1:0]          cfg_wdata_i,
  output logic [xif_core_pkg::XLEN-1:0]          cfg_rdata_o
);

  import xif_core_pkg::*;
  import xif_copro_pkg::*;

  logic                      iss_valid;
  logic                      iss_ready;
  logic [COPRO_ID_WIDTH-1:0] iss_id;
  copro_instr_u              iss_instr;
  logic [XLEN-1:0]           iss_rs0;
  logic [XLEN-1:0]           iss_rs1;
  logic [XLEN-1:0]           iss_rs2;
  logic [COPRO_NUM_RS-1:0]   iss_rs_valid;
  logic                      iss_accept;
  logic                      iss_writeback;
  logic                      res_valid;
  logic                      res_ready;
  logic [COPRO_ID_WIDTH-1:0] res_id;
  logic [XLEN-1:0]           res_data;
  logic [RF_ADDR_WIDTH-1:0]  res_rd;
  logic                      res_we;
  logic                      accept_pulse;
  logic                      copro_enable;

  xif_adapter u_adapter (
    .clk_i, .rst_n_i,
    .x_issue_valid_i, .x_issue_ready_o, .x_issue_id_i, .x_issue_instr_i,
    .x_issue_rs0_i, .x_issue_rs1_i, .x_issue_rs_valid_i,
    .x_issue_accept_o, .x_issue_writeback_o, .x_issue_register_read_o,
    .x_commit_valid_i, .x_commit_id_i, .x_commit_kill_i,
    .x_result_valid_o, .x_result_ready_i, .x_result_id_o,
    .x_result_data_o, .x_result_rd_o, .x_result_we_o,
    .copro_issue_valid_o(iss_valid), .copro_issue_ready_i(iss_ready),
    .copro_issue_id_o(iss_id), .copro_issue_instr_o(iss_instr),
    .copro_issue_rs0_o(iss_rs0), .copro_issue_rs1_o(iss_rs1),
    .copro_issue_rs2_o(iss_rs2), .copro_issue_rs_valid_o(iss_rs_valid),
    .copro_issue_accept_i(iss_accept), .copro_issue_writeback_i(iss_writeback),
    .copro_result_valid_i(res_valid), .copro_result_ready_o(res_ready),
    .copro_result_id_i(res_id), .copro_result_data_i(res_data),
    .copro_result_rd_i(res_rd), .copro_result_we_i(res_we)
  );

  xif_copro_alu u_copro_alu (
    .clk_i, .rst_n_i,
    .enable_i(copro_enable),
    .valid_i(iss_valid), .ready_o(iss_ready), .id_i(iss_id), .instr_i(iss_instr),
    .rs0_i(iss_rs0), .rs1_i(iss_rs1), .rs2_i(iss_rs2), .rs_valid_i(iss_rs_valid),
    .accept_o(iss_accept), .writeback_o(iss_writeback),
    .valid_o(res_valid), .ready_i(res_ready), .id_o(res_id),
    .data_o(res_data), .rd_o(res_rd), .we_o(res_we),
    .accept_pulse_o(accept_pulse)
  );

  xif_cfg_regs u_cfg_regs (
    .clk_i, .rst_n_i,
    .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .accept_pulse_i(accept_pulse),
    .enable_o(copro_enable)
  );

endmodule

//--- verification/xif_subsys_tb.sv
/*
 * Extension subsystem testbench with a core-side LFSR driver,
 * reference model and assertion-based monitor
 */
module xif_subsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import xif_core_pkg::*;
  import xif_copro_pkg::*;

  localparam int ISSUE_TIMEOUT = 64;
  localparam int DRAIN_TIMEOUT = 200;

  typedef struct packed {
    logic [CORE_ID_WIDTH-1:0] id;
    logic [XLEN-1:0]          data;
    logic [RF_ADDR_WIDTH-1:0] rd;
  } exp_t;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     x_issue_valid_i;
  logic                     x_issue_ready_o;
  logic [CORE_ID_WIDTH-1:0] x_issue_id_i;
  logic [INSTR_WIDTH-1:0]   x_issue_instr_i;
  logic [XLEN-1:0]          x_issue_rs0_i;
  logic [XLEN-1:0]          x_issue_rs1_i;
  logic [CORE_NUM_RS-1:0]   x_issue_rs_valid_i;
  logic                     x_issue_accept_o;
  logic                     x_issue_writeback_o;
  logic [CORE_NUM_RS-1:0]   x_issue_register_read_o;
  logic                     x_commit_valid_i;
  logic [CORE_ID_WIDTH-1:0] x_commit_id_i;
  logic                     x_commit_kill_i;
  logic                     x_result_valid_o;
  logic                     x_result_ready_i;
  logic [CORE_ID_WIDTH-1:0] x_result_id_o;
  logic [XLEN-1:0]          x_result_data_o;
  logic [RF_ADDR_WIDTH-1:0] x_result_rd_o;
  logic                     x_result_we_o;
  logic                     cfg_we_i;
  logic                     cfg_addr_i;
  logic [XLEN-1:0]          cfg_wdata_i;
  logic [XLEN-1:0]          cfg_rdata_o;

  // Model and bookkeeping state
  exp_t                     expect_q[$];
  logic [CORE_ID_WIDTH-1:0] commit_q[$];
  logic [31:0]              lfsr_state = 32'hd78a_300f;
  logic [CORE_ID_WIDTH-1:0] next_id = '0;
  logic                     issue_fired = 1'b0;
  logic                     en_model = 1'b0;
  logic                     timed_out = 1'b0;
  int                       commit_wait = 0;
  int                       n_accepted = 0;
  int                       n_results = 0;
  int                       errors = 0;

  // Last cycle's result channel for the hold check
  logic                     prev_valid = 1'b0;
  logic                     prev_ready = 1'b0;
  logic [CORE_ID_WIDTH-1:0] prev_id;
  logic [XLEN-1:0]          prev_data;
  logic [RF_ADDR_WIDTH-1:0] prev_rd;
  logic                     prev_we;

  xif_subsys_top DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic legal_instr(input logic [31:0] instr, input logic [1:0] rsv);
    logic [2:0] f3;
    f3 = instr[14:12];
    case (instr[6:0])
      OPC_CUSTOM0: return (instr[31:25] == 7'd0) && (&rsv) &&
                          (f3 == F3_MIN || f3 == F3_MAX || f3 == F3_ABSDIFF);
      OPC_CUSTOM1: return rsv[0] && (f3 == F3_ADDI || f3 == F3_RORI);
      default:     return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_result(input logic [31:0] instr,
                                               input logic [31:0] a, input logic [31:0] b);
    logic [31:0]        imm;
    logic [4:0]         sh;
    logic signed [32:0] diff;
    imm  = {{20{instr[31]}}, instr[31:20]};
    sh   = instr[24:20];
    diff = $signed({a[31], a}) - $signed({b[31], b});
    if (instr[6:0] == OPC_CUSTOM1) begin
      if (instr[14:12] == F3_RORI) begin
        return (a >> sh) | (a << (6'd32 - {1'b0, sh}));
      end
      return a + imm;
    end
    // Sign of the widened difference orders the two operands
    case (instr[14:12])
      F3_MIN:  return diff[32] ? a : b;
      F3_MAX:  return diff[32] ? b : a;
      default: return diff[32] ? 32'(-diff) : diff[31:0];
    endcase
  endfunction

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    errors++;
    $display("error at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, want);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("At %0t ns: %s", $time, what);
  endtask

  // Monitor sampling everything at the rising edge
  always @(posedge clk_i) begin
    exp_t e;
    int   idx;
    if (!rst_n_i) begin
      issue_fired = 1'b0;
      prev_valid  = 1'b0;
    end else begin
      issue_fired = x_issue_valid_i && x_issue_ready_o;
      if (!en_model && x_issue_valid_i && expect_q.size() == 0) begin
        assert (x_issue_ready_o) else report_problem("issue ready low while disabled");
      end
      if (issue_fired) begin
        assert (x_issue_accept_o == (en_model && legal_instr(x_issue_instr_i, x_issue_rs_valid_i)))
          else value_error("x_issue_accept_o", 32'(x_issue_accept_o), 32'(!x_issue_accept_o));
        assert (x_issue_register_read_o == 2'b11)
          else value_error("x_issue_register_read_o", 32'(x_issue_register_read_o), 32'd3);
        if (x_issue_accept_o) begin
          assert (x_issue_writeback_o) else value_error("x_issue_writeback_o", 32'd0, 32'd1);
          n_accepted++;
          commit_q.push_back(x_issue_id_i);
          e.id   = x_issue_id_i;
          e.data = model_result(x_issue_instr_i, x_issue_rs0_i, x_issue_rs1_i);
          e.rd   = x_issue_instr_i[11:7];
          expect_q.push_back(e);
        end
      end
      // Killed ids leave the model and must never show up
      if (x_commit_valid_i && x_commit_kill_i) begin
        for (idx = 0; idx < expect_q.size(); idx++) begin
          if (expect_q[idx].id == x_commit_id_i) begin
            expect_q.delete(idx);
            break;
          end
        end
      end
      if (x_result_valid_o) begin
        assert (expect_q.size() > 0) else report_problem("result offered with none outstanding");
      end
      if (prev_valid && !prev_ready) begin
        assert (x_result_valid_o) else report_problem("result valid dropped before handshake");
        assert (x_result_id_o == prev_id)
          else value_error("x_result_id_o", 32'(x_result_id_o), 32'(prev_id));
        assert (x_result_data_o == prev_data)
          else value_error("x_result_data_o", x_result_data_o, prev_data);
        assert (x_result_rd_o == prev_rd)
          else value_error("x_result_rd_o", 32'(x_result_rd_o), 32'(prev_rd));
        assert (x_result_we_o == prev_we)
          else value_error("x_result_we_o", 32'(x_result_we_o), 32'(prev_we));
      end
      if (x_result_valid_o && x_result_ready_i && expect_q.size() > 0) begin
        e = expect_q.pop_front();
        n_results++;
        assert (x_result_id_o == e.id)
          else value_error("x_result_id_o", 32'(x_result_id_o), 32'(e.id));
        assert (x_result_data_o == e.data)
          else value_error("x_result_data_o", x_result_data_o, e.data);
        assert (x_result_rd_o == e.rd)
          else value_error("x_result_rd_o", 32'(x_result_rd_o), 32'(e.rd));
        assert (x_result_we_o) else value_error("x_result_we_o", 32'd0, 32'd1);
      end
      prev_valid = x_result_valid_o;
      prev_ready = x_result_ready_i;
      prev_id    = x_result_id_o;
      prev_data  = x_result_data_o;
      prev_rd    = x_result_rd_o;
      prev_we    = x_result_we_o;
      // Config writes land at this edge after the accept check above
      if (cfg_we_i) begin
        if (cfg_addr_i == CFG_ADDR_CTRL) begin
          en_model = cfg_wdata_i[0];
        end else begin
          n_accepted = 0;
        end
      end
    end
  end

  // Mix of listed ops and the three kinds of illegal requests
  task automatic new_issue();
    logic [2:0] kind;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] opc;
    logic [1:0] rsv;
    kind = 3'(random_bits(3));
    f7   = '0;
    rsv  = 2'b11;
    case (kind)
      3'd0: begin
        opc = OPC_CUSTOM0;
        f3  = F3_MIN;
      end
      3'd1: begin
        opc = OPC_CUSTOM0;
        f3  = F3_MAX;
      end
      3'd2: begin
        opc = OPC_CUSTOM0;
        f3  = F3_ABSDIFF;
      end
      3'd3: begin
        opc = OPC_CUSTOM1;
        f3  = F3_ADDI;
      end
      3'd4: begin
        opc = OPC_CUSTOM1;
        f3  = F3_RORI;
      end
      3'd5: begin
        opc = 7'(random_bits(7));
        f3  = 3'(random_bits(3));
      end
      3'd6: begin
        opc = OPC_CUSTOM0;
        f3  = 3'(random_bits(3));
        f7  = 7'(random_bits(7)) | 7'd1;
      end
      default: begin
        opc = (random_bits(1) != 0) ? OPC_CUSTOM0 : OPC_CUSTOM1;
        f3  = F3_MIN;
        rsv = 2'(random_bits(2));
        // R-type misses either source, I-type always misses rs0
        if (opc == OPC_CUSTOM1 || rsv == 2'b11) begin
          rsv[0] = 1'b0;
        end
      end
    endcase
    x_issue_instr_i = {12'(random_bits(12)), 5'(random_bits(5)), f3, 5'(random_bits(5)), opc};
    if (opc == OPC_CUSTOM0 && kind != 3'd5) begin
      x_issue_instr_i[31:25] = f7;
    end
    x_issue_rs0_i      = random_bits(32);
    x_issue_rs1_i      = random_bits(32);
    x_issue_rs_valid_i = rsv;
    x_issue_id_i       = next_id;
    x_issue_valid_i    = 1'b1;
    next_id            = next_id + 1'b1;
  endtask

  // In-order commits after a random gap of 0 to 3 cycles
  task automatic step_commit(input logic kill_on);
    x_commit_valid_i = 1'b0;
    x_commit_kill_i  = 1'b0;
    if (commit_q.size() > 0) begin
      if (commit_wait == 0) begin
        x_commit_valid_i = 1'b1;
        x_commit_id_i    = commit_q.pop_front();
        x_commit_kill_i  = kill_on && (random_bits(2) == 0);
        commit_wait      = int'(random_bits(2));
      end else begin
        commit_wait--;
      end
    end
  endtask

  task automatic run_traffic(input int count, input logic kill_on, input logic bp_on);
    int sent;
    int stall;
    sent  = 0;
    stall = 0;
    new_issue();
    while (sent < count && !timed_out) begin
      @(posedge clk_i);
      #5;
      step_commit(kill_on);
      x_result_ready_i = bp_on ? (random_bits(1) != 0) : 1'b1;
      if (issue_fired) begin
        sent++;
        stall = 0;
        if (sent < count) begin
          new_issue();
        end else begin
          x_issue_valid_i = 1'b0;
        end
      end else if (++stall > ISSUE_TIMEOUT) begin
        report_problem("timeout waiting for the issue handshake");
        timed_out = 1'b1;
      end
    end
  endtask

  // Finish outstanding commits and collect every expected result
  task automatic drain(input logic kill_on);
    int stall;
    stall = 0;
    x_issue_valid_i = 1'b0;
    while ((commit_q.size() > 0 || expect_q.size() > 0) && !timed_out) begin
      @(posedge clk_i);
      #5;
      step_commit(kill_on);
      x_result_ready_i = 1'b1;
      if (++stall > DRAIN_TIMEOUT) begin
        report_problem("timeout waiting for outstanding results");
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic cfg_write(input logic addr, input logic [31:0] data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk_i);
    #5;
    cfg_we_i = 1'b0;
  endtask

  // Read data is combinational and looked at half a cycle later
  task automatic cfg_read_check(input logic addr, input logic [31:0] want);
    cfg_addr_i = addr;
    @(negedge clk_i);
    assert (cfg_rdata_o == want) else value_error("cfg_rdata_o", cfg_rdata_o, want);
    @(posedge clk_i);
    #5;
  endtask

  task automatic run_phases();
    // Out of reset the coprocessor refuses everything
    cfg_read_check(CFG_ADDR_CTRL, 32'd0);
    cfg_read_check(CFG_ADDR_COUNT, 32'd0);
    run_traffic(16, 1'b0, 1'b0);
    if (timed_out) return;
    cfg_write(CFG_ADDR_CTRL, 32'd1);
    cfg_read_check(CFG_ADDR_CTRL, 32'd1);
    run_traffic(150, 1'b0, 1'b0);
    drain(1'b0);
    if (timed_out) return;
    // Kills and random result back-pressure
    run_traffic(250, 1'b1, 1'b1);
    drain(1'b1);
    if (timed_out) return;
    cfg_read_check(CFG_ADDR_COUNT, n_accepted);
    cfg_write(CFG_ADDR_COUNT, 32'd0);
    cfg_read_check(CFG_ADDR_COUNT, 32'd0);
  endtask

  initial begin
    rst_n_i            = 1'b0;
    x_issue_valid_i    = 1'b0;
    x_issue_id_i       = '0;
    x_issue_instr_i    = '0;
    x_issue_rs0_i      = '0;
    x_issue_rs1_i      = '0;
    x_issue_rs_valid_i = '0;
    x_commit_valid_i   = 1'b0;
    x_commit_id_i      = '0;
    x_commit_kill_i    = 1'b0;
    x_result_ready_i   = 1'b1;
    cfg_we_i           = 1'b0;
    cfg_addr_i         = 1'b0;
    cfg_wdata_i        = '0;
    repeat (8) @(posedge clk_i);
    #5;
    rst_n_i = 1'b1;
    run_phases();
    $display("Errors: %0d, results checked: %0d", errors, n_results);
    if (errors == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog.f
hw/xif_core_pkg.sv
hw/xif_copro_pkg.sv
hw/xif_adapter.sv
hw/xif_copro_alu.sv
hw/xif_cfg_regs.sv
hw/xif_subsys_top.sv
verification/xif_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile the subsystem testbench with Verilator, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module xif_subsys_tb -f verilog.f -o xif_subsys_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/xif_subsys_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0
